/* Makefile */
# Verilator flow for the vote testbench; override any variable on the command line

VERILATOR ?= verilator
TOP       ?= vote_tb
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "sim failed" $(LOG); then echo "FAIL: see $(LOG)"; exit 1; fi
	@if ! grep -q "sim passed" $(LOG); then echo "FAIL: no result in $(LOG)"; exit 1; fi
	@echo "PASS"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* rtl/core_pkg.sv */
`default_nettype none

package core_pkg;

    // threshold and compare width
    localparam int THRESH_W = 16;

    // xorshift32 state
    localparam int RNG_W = 32;
    localparam logic [RNG_W-1:0] RNG_SEED_BASE = 32'h2545_f491;

    // classic 13/17/5 shift triple
    localparam int XS_A = 13;
    localparam int XS_B = 17;
    localparam int XS_C = 5;

    // one generator step
    function automatic logic [RNG_W-1:0] xorshift_step(input logic [RNG_W-1:0] s);
        logic [RNG_W-1:0] x;
        x = s;
        x = x ^ (x << XS_A);
        x = x ^ (x >> XS_B);
        x = x ^ (x << XS_C);
        return x;
    endfunction

    // base xor (k+1), never zero for small k
    function automatic logic [RNG_W-1:0] seed_for(input int unsigned k);
        return RNG_SEED_BASE ^ RNG_W'(k + 1);
    endfunction

endpackage

`default_nettype wire

/* rtl/stochastic_core_bank.sv */
`timescale 1ns/10ps
`default_nettype none

module stochastic_core_bank
    import core_pkg::*;
#(
    parameter int N_CORES = 16
) (
    input  wire logic                        clk,
    input  wire logic                        rst,
    input  wire logic                        update,
    // flat bus with core k at bits [k*THRESH_W +: THRESH_W]
    input  wire logic [N_CORES*THRESH_W-1:0] threshold,
    output logic      [N_CORES-1:0]          core_result,
    output logic                             result_strobe
);

    // strobe lags update by one cycle like the results
    always_ff @(posedge clk) begin
        if (rst) begin
            result_strobe <= 1'b0;
        end else begin
            result_strobe <= update;
        end
    end

    genvar k;
    generate
        for (k = 0; k < N_CORES; k = k + 1) begin : g_core
            localparam logic [RNG_W-1:0] SEED = seed_for(k);

            logic [RNG_W-1:0]    rng_state;
            logic [RNG_W-1:0]    rng_next;
            logic [THRESH_W-1:0] core_thresh;

            assign rng_next    = xorshift_step(rng_state);
            assign core_thresh = threshold[k*THRESH_W +: THRESH_W];

            // generator only moves on update
            always_ff @(posedge clk) begin
                if (rst) begin
                    rng_state <= SEED;
                end else if (update) begin
                    rng_state <= rng_next;
                end
            end

            // compare low bits of the fresh draw
            // all-ones threshold always passes
            always_ff @(posedge clk) begin
                if (update) begin
                    core_result[k] <= (rng_next[THRESH_W-1:0] <= core_thresh);
                end
            end
        end
    endgenerate

    // results must appear exactly one cycle after update
    a_strobe_follows_update: assert property (
        @(posedge clk) disable iff (rst)
        update |=> result_strobe
    );

endmodule

`default_nettype wire

/* rtl/vote_counter.sv */
`timescale 1ns/10ps
`default_nettype none

module vote_counter
    import vote_pkg::*;
#(
    parameter int N_CORES = 16,
    parameter int ACC_W   = 30
) (
    input  wire logic                      clk,
    input  wire logic                      rst,
    input  wire logic                      start,
    input  wire logic                      tie_bit,
    input  wire logic [N_CORES-1:0]        core_enable,
    input  wire vote_t [N_CORES-1:0]       votes,
    input  wire logic                      vote_strobe,
    output logic signed [ACC_W-1:0]        tally,
    output logic                           sign_bit
);

    // round sum spans -N_CORES..+N_CORES
    localparam int SUM_W  = $clog2(N_CORES + 1) + 1;
    // tree padded up to a power of two
    localparam int LEVELS = $clog2(N_CORES);
    localparam int LEAVES = 2 ** LEVELS;

    // heap layout, node 1 is the root
    logic signed [SUM_W-1:0] node [1:2*LEAVES-1];
    logic signed [SUM_W-1:0] round_sum;

    logic signed [ACC_W:0]   tally_wide;
    logic signed [ACC_W-1:0] preload;
    logic                    enable_even;
    vote_t                   tie_vote;

    genvar i;
    generate
        // leaves, sign extended votes, zero padding past N_CORES
        for (i = 0; i < LEAVES; i = i + 1) begin : g_leaf
            if (i < N_CORES) begin : g_used
                assign node[LEAVES+i] = {{(SUM_W-VOTE_W){votes[i][VOTE_W-1]}}, votes[i]};
            end else begin : g_pad
                assign node[LEAVES+i] = '0;
            end
        end
        // pairwise adds toward the root
        for (i = 1; i < LEAVES; i = i + 1) begin : g_node
            assign node[i] = node[2*i] + node[2*i+1];
        end
    endgenerate

    assign round_sum = node[1];

    // one extra bit to catch overflow
    assign tally_wide = {tally[ACC_W-1], tally}
                      + {{(ACC_W+1-SUM_W){round_sum[SUM_W-1]}}, round_sum};

    // even popcount when the xor of all enables is 0
    assign enable_even = ~(^core_enable);
    assign tie_vote    = tie_bit ? TIE_NEG : TIE_POS;

    // odd count cannot tie, so no bias needed
    assign preload = enable_even ?
                     {{(ACC_W-VOTE_W){tie_vote[VOTE_W-1]}}, tie_vote} : '0;

    always_ff @(posedge clk) begin
        if (rst) begin
            tally <= '0;
        end else if (start) begin
            tally <= preload;
        end else if (vote_strobe) begin
            tally <= tally_wide[ACC_W-1:0];
        end
    end

    // negative tally means majority voted 0
    assign sign_bit = tally[ACC_W-1];

    // preload and a round landing together would drop one of them
    a_start_not_during_round: assert property (
        @(posedge clk) disable iff (rst)
        !(start && vote_strobe)
    );

    // top two bits of the wide sum must agree
    a_tally_no_overflow: assert property (
        @(posedge clk) disable iff (rst)
        vote_strobe |-> (tally_wide[ACC_W] == tally_wide[ACC_W-1])
    );

endmodule

`default_nettype wire

/* rtl/vote_pkg.sv */
`default_nettype none

package vote_pkg;

    // one signed vote per core
    localparam int VOTE_W = 2;

    typedef logic signed [VOTE_W-1:0] vote_t;

    // the three legal vote values
    localparam vote_t VOTE_POS  = 2'sb01;
    localparam vote_t VOTE_ZERO = 2'sb00;
    localparam vote_t VOTE_NEG  = 2'sb11;

    // tally preload on an even core count
    localparam vote_t TIE_POS = VOTE_POS;
    localparam vote_t TIE_NEG = VOTE_NEG;

    // result 1 votes up, result 0 votes down, disabled core abstains
    function automatic vote_t to_vote(input logic result, input logic enable);
        if (!enable) begin
            return VOTE_ZERO;
        end
        return result ? VOTE_POS : VOTE_NEG;
    endfunction

    // 2'b10 is the only illegal code
    function automatic logic vote_legal(input vote_t v);
        return (v == VOTE_POS) || (v == VOTE_ZERO) || (v == VOTE_NEG);
    endfunction

endpackage

`default_nettype wire

/* rtl/vote_register.sv */
`timescale 1ns/10ps
`default_nettype none

module vote_register
    import vote_pkg::*;
#(
    parameter int N_CORES = 16
) (
    input  wire logic                clk,
    input  wire logic                rst,
    input  wire logic [N_CORES-1:0]  core_result,
    input  wire logic [N_CORES-1:0]  core_enable,
    input  wire logic                result_strobe,
    output vote_t     [N_CORES-1:0]  votes,
    output logic                     vote_strobe
);

    // strobe delayed one more stage
    always_ff @(posedge clk) begin
        if (rst) begin
            vote_strobe <= 1'b0;
        end else begin
            vote_strobe <= result_strobe;
        end
    end

    genvar k;
    generate
        for (k = 0; k < N_CORES; k = k + 1) begin : g_vote
            // vote held until the next round
            always_ff @(posedge clk) begin
                if (result_strobe) begin
                    votes[k] <= to_vote(core_result[k], core_enable[k]);
                end
            end

            // whatever reaches the counter must be +1, 0 or -1
            a_vote_legal: assert property (
                @(posedge clk) disable iff (rst)
                vote_strobe |-> vote_legal(votes[k])
            );
        end
    endgenerate

endmodule

`default_nettype wire

/* rtl/vote_top.sv */
`timescale 1ns/10ps
`default_nettype none

module vote_top
    import core_pkg::*;
    import vote_pkg::*;
#(
    parameter int N_CORES = 16,
    parameter int ACC_W   = 30
) (
    input  wire logic                        clk,
    input  wire logic                        rst,
    input  wire logic                        start,
    input  wire logic                        update,
    input  wire logic                        tie_bit,
    input  wire logic [N_CORES-1:0]          core_enable,
    input  wire logic [N_CORES*THRESH_W-1:0] threshold,
    output logic signed [ACC_W-1:0]          tally,
    output logic                             sign_bit
);

    // stage 1 to stage 2
    logic [N_CORES-1:0] core_result;
    logic               result_strobe;

    // stage 2 to stage 3
    vote_t [N_CORES-1:0] votes;
    logic                vote_strobe;

    // random draw and threshold compare
    stochastic_core_bank #(
        .N_CORES       (N_CORES)
    ) core_bank_inst (
        .clk           (clk),
        .rst           (rst),
        .update        (update),
        .threshold     (threshold),
        .core_result   (core_result),
        .result_strobe (result_strobe)
    );

    // result and enable to signed vote
    vote_register #(
        .N_CORES       (N_CORES)
    ) vote_register_inst (
        .clk           (clk),
        .rst           (rst),
        .core_result   (core_result),
        .core_enable   (core_enable),
        .result_strobe (result_strobe),
        .votes         (votes),
        .vote_strobe   (vote_strobe)
    );

    // tally, preload and sign
    vote_counter #(
        .N_CORES     (N_CORES),
        .ACC_W       (ACC_W)
    ) vote_counter_inst (
        .clk         (clk),
        .rst         (rst),
        .start       (start),
        .tie_bit     (tie_bit),
        .core_enable (core_enable),
        .votes       (votes),
        .vote_strobe (vote_strobe),
        .tally       (tally),
        .sign_bit    (sign_bit)
    );

endmodule

`default_nettype wire

/* src.f */
rtl/vote_pkg.sv
rtl/core_pkg.sv
rtl/stochastic_core_bank.sv
rtl/vote_register.sv
rtl/vote_counter.sv
rtl/vote_top.sv
verification/tb_clock_gen.sv
verification/vote_tb.sv

/* verification/tb_clock_gen.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen #(
    // half of the 4 ns period
    parameter int HALF_PERIOD = 2
) (
    output logic clk
);

    // free running, low at time zero
    initial begin
        clk = 1'b0;
        forever begin
            #HALF_PERIOD clk = ~clk;
        end
    end

endmodule

`default_nettype wire

/* verification/vote_golden.dat */
// enable  thresh_mask  tie  updates  tally(2s compl)  sign, all hex
// odd count, preload zero for either tie bit
0007 0007 0 0 00000000 0
0007 0000 1 0 00000000 0
// even count, tie break
000f 000f 0 0 00000001 0
000f 000f 1 0 ffffffff 1
// mixed masks
00ff 003f 0 4 00000011 0
00ff 0007 1 3 fffffff9 1
001f 0003 0 2 fffffffe 1
// disabled cores with all ones thresholds
000f ffff 1 5 00000013 0
0f0f f00f 0 6 00000001 0
0001 fffe 0 3 fffffffd 1
// longer runs, gaps mostly zero
ffff ffff 0 c 000000c1 0
ffff 0000 1 6 ffffff9f 1
7fff 00ff 1 8 00000008 0

/* verification/vote_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module vote_tb
    import core_pkg::*;
();

    localparam int    N_CORES   = 16;
    localparam int    ACC_W     = 30;
    // words per golden line
    localparam int    FIELDS    = 6;
    localparam int    MAX_TESTS = 32;
    localparam string GOLDEN    = "verification/vote_golden.dat";

    logic                        clk;
    logic                        rst;
    logic                        start;
    logic                        update;
    logic                        tie_bit;
    logic [N_CORES-1:0]          core_enable;
    logic [N_CORES*THRESH_W-1:0] threshold;
    logic signed [ACC_W-1:0]     tally;
    logic                        sign_bit;

    logic [31:0] golden_mem [0:FIELDS*MAX_TESTS-1];

    int          error_count = 0;
    int          num_tests   = 0;
    int          cycle_count = 0;
    int          cycle_limit = 0;
    logic [31:0] lcg_state   = 32'd28;

    tb_clock_gen #(
        .HALF_PERIOD (2)
    ) clock_gen_inst (
        .clk (clk)
    );

    vote_top #(
        .N_CORES     (N_CORES),
        .ACC_W       (ACC_W)
    ) vote_top_inst (
        .clk         (clk),
        .rst         (rst),
        .start       (start),
        .update      (update),
        .tie_bit     (tie_bit),
        .core_enable (core_enable),
        .threshold   (threshold),
        .tally       (tally),
        .sign_bit    (sign_bit)
    );

    // watchdog, limit set once the golden file is read
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            $display("run timed out after %0d cycles (limit %0d)", cycle_count, cycle_limit);
            $display("sim failed");
            $finish;
        end
    end

    // marks unused memory words, differs per address
    function automatic logic [31:0] fill_word(input int addr);
        return 32'hdead_0000 ^ 32'(addr);
    endfunction

    // 32-bit lcg, numerical recipes constants
    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic int count_ones(input logic [N_CORES-1:0] v);
        int n;
        n = 0;
        for (int i = 0; i < N_CORES; i++) begin
            if (v[i]) begin
                n++;
            end
        end
        return n;
    endfunction

    // preload plus rounds times (enabled up votes minus enabled down votes)
    function automatic int rule_tally(input logic [N_CORES-1:0] en,
                                      input logic [N_CORES-1:0] mask,
                                      input logic tie, input int rounds);
        int pre;
        int pos;
        int neg;
        pos = count_ones(en & mask);
        neg = count_ones(en & ~mask);
        if (count_ones(en) % 2 == 0) begin
            pre = tie ? -1 : 1;
        end else begin
            pre = 0;
        end
        return pre + rounds * (pos - neg);
    endfunction

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            error_count++;
            $display("Error at %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    // drive point, 1 ns past the rising edge
    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    // gap 0..3, zero favored so rounds pile up in the pipeline
    task automatic draw_gap(output int gap);
        logic [2:0] field;
        lcg_state = lcg_next(lcg_state);
        field = lcg_state[18:16];
        gap = (field > 3'd3) ? 0 : int'(field);
    endtask

    task automatic run_test(input int t);
        logic [N_CORES-1:0] en;
        logic [N_CORES-1:0] mask;
        logic               tie;
        int                 rounds;
        logic [31:0]        exp_tally;
        logic [31:0]        exp_sign;
        int                 gap;
        en        = golden_mem[t*FIELDS][N_CORES-1:0];
        mask      = golden_mem[t*FIELDS+1][N_CORES-1:0];
        tie       = golden_mem[t*FIELDS+2][0];
        rounds    = int'(golden_mem[t*FIELDS+3]);
        exp_tally = golden_mem[t*FIELDS+4];
        exp_sign  = golden_mem[t*FIELDS+5];
        // golden line must agree with the voting rule
        check_value($sformatf("test %0d golden tally", t), exp_tally,
                    rule_tally(en, mask, tie, rounds));
        core_enable = en;
        tie_bit     = tie;
        // set mask bit means always up, clear means threshold zero
        for (int k = 0; k < N_CORES; k++) begin
            threshold[k*THRESH_W +: THRESH_W] = {THRESH_W{mask[k]}};
        end
        start = 1'b1;
        next_cycle();
        start = 1'b0;
        for (int u = 0; u < rounds; u++) begin
            update = 1'b1;
            next_cycle();
            update = 1'b0;
            if (u < rounds - 1) begin
                draw_gap(gap);
                repeat (gap) next_cycle();
            end
        end
        // three stage latency to the tally
        repeat (3) next_cycle();
        check_value($sformatf("test %0d tally", t),
                    {{(32-ACC_W){tally[ACC_W-1]}}, tally}, exp_tally);
        check_value($sformatf("test %0d sign_bit", t), {31'd0, sign_bit}, exp_sign);
    endtask

    initial begin
        int rounds_total;
        rst          = 1'b1;
        start        = 1'b0;
        update       = 1'b0;
        tie_bit      = 1'b0;
        core_enable  = '0;
        threshold    = '0;
        rounds_total = 0;
        for (int i = 0; i < FIELDS*MAX_TESTS; i++) begin
            golden_mem[i] = fill_word(i);
        end
        $readmemh(GOLDEN, golden_mem);
        while (num_tests < MAX_TESTS &&
               golden_mem[num_tests*FIELDS] != fill_word(num_tests*FIELDS)) begin
            rounds_total += int'(golden_mem[num_tests*FIELDS+3]);
            num_tests++;
        end
        if (num_tests == 0) begin
            $display("no test lines found in %s", GOLDEN);
            error_count++;
        end
        // 4 cycles per round worst case, 10 per test, 20 for reset
        cycle_limit = rounds_total * 4 + num_tests * 10 + 20;

        repeat (8) next_cycle();
        rst = 1'b0;
        repeat (2) next_cycle();
        // idle after reset
        check_value("tally after reset", {{(32-ACC_W){tally[ACC_W-1]}}, tally}, 32'd0);
        check_value("sign_bit after reset", {31'd0, sign_bit}, 32'd0);

        for (int t = 0; t < num_tests; t++) begin
            run_test(t);
        end

        $display("%0d tests, %0d errors", num_tests, error_count);
        if (error_count == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
